//--- hw/qsys_cfg.svh
// Packet queue system configuration

`ifndef QSYS_CFG_SVH
`define QSYS_CFG_SVH

// Datapath and topology
`define QSYS_DATA_W         32
`define QSYS_NUM_EGR_PORTS  4
`define QSYS_NUM_ING_PORTS  4
`define QSYS_NUM_PRIO       2
`define QSYS_NUM_QUEUES     8

// Buffering and packet limits
`define QSYS_QUEUE_DEPTH    32
`define QSYS_MTU_BYTES      64
`define QSYS_BLEN_W         7
`define QSYS_CNT_W          32

// Derived widths
`define QSYS_PORT_W     ($clog2(`QSYS_NUM_EGR_PORTS))
`define QSYS_ING_W      ($clog2(`QSYS_NUM_ING_PORTS))
`define QSYS_QIDX_W     ($clog2(`QSYS_NUM_QUEUES))
`define QSYS_PTR_W      ($clog2(`QSYS_QUEUE_DEPTH))
`define QSYS_OCC_W      ($clog2(`QSYS_QUEUE_DEPTH) + 1)
`define QSYS_WCNT_W     ($clog2(`QSYS_MTU_BYTES / (`QSYS_DATA_W / 8)) + 1)

`endif

//--- hw/qsys_pkg.sv
// Packet queue system types

`include "qsys_cfg.svh"

package qsys_pkg;

    // Per-packet metadata, valid on the first word
    typedef struct packed {
        logic [`QSYS_ING_W-1:0]  ingress_port;
        logic [`QSYS_PORT_W-1:0] egress_port;
        logic                    prio;
        logic [`QSYS_BLEN_W-1:0] byte_length;
    } pkt_meta_t;

    typedef struct packed {
        logic                    valid;
        logic                    last;
        logic [`QSYS_DATA_W-1:0] data;
        pkt_meta_t               meta;
    } in_word_t;

    // Classifier to queue memory
    typedef struct packed {
        logic                    valid;
        logic                    last;
        logic [`QSYS_QIDX_W-1:0] qidx;
        logic [`QSYS_DATA_W-1:0] data;
    } wr_req_t;

    typedef struct packed {
        logic [`QSYS_NUM_QUEUES-1:0][`QSYS_OCC_W-1:0] free_words;
        logic [`QSYS_NUM_QUEUES-1:0][`QSYS_OCC_W-1:0] pkt_count;
    } queue_status_t;

    // Scheduler read port
    typedef struct packed {
        logic                    valid;
        logic [`QSYS_QIDX_W-1:0] qidx;
    } rd_req_t;

    typedef struct packed {
        logic                    valid;
        logic                    last;
        logic [`QSYS_DATA_W-1:0] data;
    } rd_word_t;

    typedef struct packed {
        logic                    valid;
        logic                    last;
        logic [`QSYS_DATA_W-1:0] data;
        logic [`QSYS_PORT_W-1:0] egress_port;
        logic                    prio;
    } out_word_t;

    typedef enum logic {
        IDLE,
        SEND
    } sched_state_e;

endpackage

//--- hw/packet_classifier.sv
// Packet classifier
// Queue mapping and whole-packet admission

`timescale 1ns/1ps
`include "qsys_cfg.svh"

module packet_classifier (
    input  logic                    core_clk_ifc,
    input  logic                    rst,
    input  qsys_pkg::in_word_t      in_word,
    input  qsys_pkg::queue_status_t q_status,
    input  logic                    in_cnt_clear,
    input  logic                    enq_cnt_clear,
    output qsys_pkg::wr_req_t       wr_req,
    output logic [`QSYS_CNT_W-1:0]  qsys_in_pkt_cnt,
    output logic [`QSYS_CNT_W-1:0]  enqueue_pkt_cnt
);

    localparam int QIDX_W     = `QSYS_QIDX_W;
    localparam int OCC_W      = `QSYS_OCC_W;
    localparam int WCNT_W     = `QSYS_WCNT_W;
    localparam int BLEN_W     = `QSYS_BLEN_W;
    localparam int WORD_BYTES = `QSYS_DATA_W / 8;

    logic                    mid_pkt;
    logic                    sop;
    logic                    admit_q;
    logic [QIDX_W-1:0]       qidx_q;
    logic [QIDX_W-1:0]       qidx_now;
    logic [BLEN_W:0]         blen_rnd;
    logic [WCNT_W-1:0]       wcnt_now;
    logic [OCC_W-1:0]        free_now;
    logic                    admit_now;
    logic                    admit_sel;
    logic [QIDX_W-1:0]       qidx_sel;
    logic                    wr_valid_q;
    logic                    wr_last_q;
    logic [QIDX_W-1:0]       wr_qidx_q;
    logic [`QSYS_DATA_W-1:0] wr_data_q;

    //////////////////////////////////////////////////////////////////////
    // Admission decision on the first word

    always_comb begin
        sop      = in_word.valid && !mid_pkt;
        qidx_now = QIDX_W'(in_word.meta.egress_port * `QSYS_NUM_PRIO + in_word.meta.prio);
        blen_rnd = {1'b0, in_word.meta.byte_length} + (BLEN_W + 1)'(WORD_BYTES - 1);
        wcnt_now = WCNT_W'(blen_rnd / WORD_BYTES);
        // Word still in flight to memory is not in the free count yet
        free_now = q_status.free_words[qidx_now];
        if (wr_valid_q && (wr_qidx_q == qidx_now)) begin
            free_now = free_now - 1'b1;
        end
        admit_now = (free_now >= OCC_W'(wcnt_now));
        admit_sel = sop ? admit_now : admit_q;
        qidx_sel  = sop ? qidx_now : qidx_q;
    end

    always_ff @(posedge core_clk_ifc) begin
        if (rst) begin
            mid_pkt    <= 1'b0;
            admit_q    <= 1'b0;
            wr_valid_q <= 1'b0;
        end else begin
            if (in_word.valid) begin
                mid_pkt <= !in_word.last;
            end
            if (sop) begin
                admit_q <= admit_now;
            end
            wr_valid_q <= in_word.valid && admit_sel;
        end
    end

    // Write payload
    always_ff @(posedge core_clk_ifc) begin
        if (sop) begin
            qidx_q <= qidx_now;
        end
        wr_last_q <= in_word.last;
        wr_qidx_q <= qidx_sel;
        wr_data_q <= in_word.data;
    end

    always_comb begin
        wr_req.valid = wr_valid_q;
        wr_req.last  = wr_last_q;
        wr_req.qidx  = wr_qidx_q;
        wr_req.data  = wr_data_q;
    end

    //////////////////////////////////////////////////////////////////////
    // Arrival and enqueue counters

    always_ff @(posedge core_clk_ifc) begin
        if (rst) begin
            qsys_in_pkt_cnt <= '0;
            enqueue_pkt_cnt <= '0;
        end else begin
            if (in_cnt_clear) begin
                qsys_in_pkt_cnt <= '0;
            end else if (sop) begin
                qsys_in_pkt_cnt <= qsys_in_pkt_cnt + 1'b1;
            end
            if (enq_cnt_clear) begin
                enqueue_pkt_cnt <= '0;
            end else if (sop && admit_now) begin
                enqueue_pkt_cnt <= enqueue_pkt_cnt + 1'b1;
            end
        end
    end

endmodule

//--- hw/queue_memory.sv
// Per-queue packet buffer

`timescale 1ns/1ps
`include "qsys_cfg.svh"

module queue_memory (
    input  logic                    core_clk_ifc,
    input  logic                    rst,
    input  qsys_pkg::wr_req_t       wr_req,
    input  qsys_pkg::rd_req_t       rd_req,
    output qsys_pkg::rd_word_t      rd_word,
    output qsys_pkg::queue_status_t q_status
);

    localparam int NUM_Q  = `QSYS_NUM_QUEUES;
    localparam int DEPTH  = `QSYS_QUEUE_DEPTH;
    localparam int PTR_W  = `QSYS_PTR_W;
    localparam int OCC_W  = `QSYS_OCC_W;
    localparam int QIDX_W = `QSYS_QIDX_W;
    localparam int DATA_W = `QSYS_DATA_W;

    // Fixed region of DEPTH words per queue, addressed as {qidx, ptr}
    logic [DATA_W-1:0]             mem [NUM_Q*DEPTH];
    logic [NUM_Q*DEPTH-1:0]        last_flag;

    logic [NUM_Q-1:0][PTR_W-1:0]   wr_ptr;
    logic [NUM_Q-1:0][PTR_W-1:0]   rd_ptr;
    logic [NUM_Q-1:0][OCC_W-1:0]   occ;
    logic [NUM_Q-1:0][OCC_W-1:0]   pkt_cnt;

    logic [QIDX_W+PTR_W-1:0]       wr_addr;
    logic [QIDX_W+PTR_W-1:0]       rd_addr;
    logic                          rd_last_now;
    logic [NUM_Q-1:0]              wr_hit;
    logic [NUM_Q-1:0]              rd_hit;
    logic [NUM_Q-1:0]              wr_eop;
    logic [NUM_Q-1:0]              rd_eop;

    logic                          rd_valid_q;
    logic                          rd_last_q;
    logic [DATA_W-1:0]             rd_data_q;

    always_comb begin
        wr_addr     = {wr_req.qidx, wr_ptr[wr_req.qidx]};
        rd_addr     = {rd_req.qidx, rd_ptr[rd_req.qidx]};
        rd_last_now = last_flag[rd_addr];
        for (int q = 0; q < NUM_Q; q++) begin
            wr_hit[q] = wr_req.valid && (wr_req.qidx == QIDX_W'(q));
            rd_hit[q] = rd_req.valid && (rd_req.qidx == QIDX_W'(q));
            wr_eop[q] = wr_hit[q] && wr_req.last;
            rd_eop[q] = rd_hit[q] && rd_last_now;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Storage

    always_ff @(posedge core_clk_ifc) begin
        if (wr_req.valid) begin
            mem[wr_addr]       <= wr_req.data;
            last_flag[wr_addr] <= wr_req.last;
        end
        if (rd_req.valid) begin
            rd_data_q <= mem[rd_addr];
            rd_last_q <= rd_last_now;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Pointers, occupancy and complete-packet counts

    always_ff @(posedge core_clk_ifc) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            occ        <= '0;
            pkt_cnt    <= '0;
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= rd_req.valid;
            for (int q = 0; q < NUM_Q; q++) begin
                if (wr_hit[q]) begin
                    wr_ptr[q] <= wr_ptr[q] + 1'b1;
                end
                if (rd_hit[q]) begin
                    rd_ptr[q] <= rd_ptr[q] + 1'b1;
                end
                occ[q]     <= occ[q] + OCC_W'(wr_hit[q]) - OCC_W'(rd_hit[q]);
                // Drops as soon as the last word of a packet is read
                pkt_cnt[q] <= pkt_cnt[q] + OCC_W'(wr_eop[q]) - OCC_W'(rd_eop[q]);
            end
        end
    end

    always_comb begin
        rd_word.valid = rd_valid_q;
        rd_word.last  = rd_last_q;
        rd_word.data  = rd_data_q;
        for (int q = 0; q < NUM_Q; q++) begin
            q_status.free_words[q] = OCC_W'(DEPTH) - occ[q];
            q_status.pkt_count[q]  = pkt_cnt[q];
        end
    end

endmodule

//--- hw/egress_scheduler.sv
// Egress scheduler
// Round-robin over ports, strict priority within a port

`timescale 1ns/1ps
`include "qsys_cfg.svh"

module egress_scheduler (
    input  logic                           core_clk_ifc,
    input  logic                           rst,
    input  qsys_pkg::queue_status_t        q_status,
    input  qsys_pkg::rd_word_t             rd_word,
    input  logic [`QSYS_NUM_EGR_PORTS-1:0] egr_buf_ready,
    input  logic                           deq_cnt_clear,
    output qsys_pkg::rd_req_t              rd_req,
    output qsys_pkg::out_word_t            out_word,
    output logic [`QSYS_CNT_W-1:0]         dequeue_pkt_cnt
);

    localparam int NUM_PORTS = `QSYS_NUM_EGR_PORTS;
    localparam int NUM_PRIO  = `QSYS_NUM_PRIO;
    localparam int PORT_W    = `QSYS_PORT_W;
    localparam int QIDX_W    = `QSYS_QIDX_W;

    qsys_pkg::sched_state_e  state;
    logic [PORT_W-1:0]       rr_ptr;
    logic [PORT_W-1:0]       cur_port;
    logic                    cur_prio;
    logic                    done_issue;

    logic                    grant_found;
    logic [PORT_W-1:0]       grant_port;
    logic                    grant_prio;

    logic                    skid_valid;
    logic                    skid_last;
    logic [`QSYS_DATA_W-1:0] skid_data;

    logic                    port_ready;
    logic                    last_returned;
    logic                    issue;
    logic                    src_valid;
    logic                    src_last;
    logic [`QSYS_DATA_W-1:0] src_data;
    logic                    emit;

    //////////////////////////////////////////////////////////////////////
    // Port arbitration, starting at the round-robin pointer

    always_comb begin
        logic [PORT_W-1:0] cand;
        int                lo_idx;
        logic              has_hi;
        logic              has_lo;
        grant_found = 1'b0;
        grant_port  = rr_ptr;
        grant_prio  = 1'b0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            cand   = PORT_W'(rr_ptr + PORT_W'(i));
            lo_idx = int'(cand) * NUM_PRIO;
            has_lo = (q_status.pkt_count[lo_idx] != '0);
            has_hi = (q_status.pkt_count[lo_idx + 1] != '0);
            if (!grant_found && egr_buf_ready[cand] && (has_hi || has_lo)) begin
                grant_found = 1'b1;
                grant_port  = cand;
                grant_prio  = has_hi;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read issue and output path

    always_comb begin
        port_ready    = egr_buf_ready[cur_port];
        last_returned = rd_word.valid && rd_word.last;
        // No read after the last word has come back
        issue     = (state == qsys_pkg::SEND) && port_ready && !done_issue && !last_returned;
        src_valid = skid_valid || rd_word.valid;
        src_last  = skid_valid ? skid_last : rd_word.last;
        src_data  = skid_valid ? skid_data : rd_word.data;
        emit      = src_valid && port_ready;

        rd_req.valid = issue;
        rd_req.qidx  = QIDX_W'(cur_port * NUM_PRIO + cur_prio);

        out_word.valid       = emit;
        out_word.last        = src_last;
        out_word.data        = src_data;
        out_word.egress_port = cur_port;
        out_word.prio        = cur_prio;
    end

    always_ff @(posedge core_clk_ifc) begin
        if (rst) begin
            state      <= qsys_pkg::IDLE;
            rr_ptr     <= '0;
            cur_port   <= '0;
            cur_prio   <= 1'b0;
            done_issue <= 1'b0;
            skid_valid <= 1'b0;
        end else begin
            case (state)
                qsys_pkg::IDLE: begin
                    if (grant_found) begin
                        state      <= qsys_pkg::SEND;
                        cur_port   <= grant_port;
                        cur_prio   <= grant_prio;
                        rr_ptr     <= grant_port + 1'b1;
                        done_issue <= 1'b0;
                    end
                end
                qsys_pkg::SEND: begin
                    if (last_returned) begin
                        done_issue <= 1'b1;
                    end
                    if (emit && src_last) begin
                        state <= qsys_pkg::IDLE;
                    end
                end
                default: state <= qsys_pkg::IDLE;
            endcase

            // Word returned while the port is not ready waits here
            if (rd_word.valid && !port_ready) begin
                skid_valid <= 1'b1;
            end else if (skid_valid && port_ready) begin
                skid_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (rd_word.valid && !port_ready) begin
            skid_data <= rd_word.data;
            skid_last <= rd_word.last;
        end
    end

    // Dequeue counter
    always_ff @(posedge core_clk_ifc) begin
        if (rst) begin
            dequeue_pkt_cnt <= '0;
        end else if (deq_cnt_clear) begin
            dequeue_pkt_cnt <= '0;
        end else if (emit && src_last) begin
            dequeue_pkt_cnt <= dequeue_pkt_cnt + 1'b1;
        end
    end

endmodule

//--- hw/queue_system.sv
// Packet queue system top level

`timescale 1ns/1ps
`include "qsys_cfg.svh"

module queue_system (
    input  logic                           core_clk_ifc,
    input  logic                           rst,
    input  qsys_pkg::in_word_t             in_word,
    input  logic [`QSYS_NUM_EGR_PORTS-1:0] egr_buf_ready,
    input  logic                           in_cnt_clear,
    input  logic                           enq_cnt_clear,
    input  logic                           deq_cnt_clear,
    output qsys_pkg::out_word_t            out_word,
    output logic [`QSYS_CNT_W-1:0]         qsys_in_pkt_cnt,
    output logic [`QSYS_CNT_W-1:0]         enqueue_pkt_cnt,
    output logic [`QSYS_CNT_W-1:0]         dequeue_pkt_cnt
);

    qsys_pkg::wr_req_t       wr_req;
    qsys_pkg::rd_req_t       rd_req;
    qsys_pkg::rd_word_t      rd_word;
    qsys_pkg::queue_status_t q_status;

    //////////////////////////////////////////////////////////////////////
    // Producer

    packet_classifier classifier_inst (
        .core_clk_ifc    (core_clk_ifc),
        .rst             (rst),
        .in_word         (in_word),
        .q_status        (q_status),
        .in_cnt_clear    (in_cnt_clear),
        .enq_cnt_clear   (enq_cnt_clear),
        .wr_req          (wr_req),
        .qsys_in_pkt_cnt (qsys_in_pkt_cnt),
        .enqueue_pkt_cnt (enqueue_pkt_cnt)
    );

    //////////////////////////////////////////////////////////////////////
    // Buffer

    queue_memory memory_inst (
        .core_clk_ifc (core_clk_ifc),
        .rst          (rst),
        .wr_req       (wr_req),
        .rd_req       (rd_req),
        .rd_word      (rd_word),
        .q_status     (q_status)
    );

    //////////////////////////////////////////////////////////////////////
    // Consumer

    egress_scheduler scheduler_inst (
        .core_clk_ifc    (core_clk_ifc),
        .rst             (rst),
        .q_status        (q_status),
        .rd_word         (rd_word),
        .egr_buf_ready   (egr_buf_ready),
        .deq_cnt_clear   (deq_cnt_clear),
        .rd_req          (rd_req),
        .out_word        (out_word),
        .dequeue_pkt_cnt (dequeue_pkt_cnt)
    );

endmodule

//--- test/queue_system_tb.sv
// Queue system testbench

`timescale 1ns/1ps
`include "qsys_cfg.svh"

module queue_system_tb;

    localparam int NUM_Q        = `QSYS_NUM_QUEUES;
    localparam int BLOCKED_PORT = 2;
    localparam int WAIT_LIMIT   = 2000;

    logic                           core_clk_ifc;
    logic                           rst;
    qsys_pkg::in_word_t             in_word;
    logic [`QSYS_NUM_EGR_PORTS-1:0] egr_buf_ready;
    logic                           in_cnt_clear;
    logic                           enq_cnt_clear;
    logic                           deq_cnt_clear;
    qsys_pkg::out_word_t            out_word;
    logic [`QSYS_CNT_W-1:0]         qsys_in_pkt_cnt;
    logic [`QSYS_CNT_W-1:0]         enqueue_pkt_cnt;
    logic [`QSYS_CNT_W-1:0]         dequeue_pkt_cnt;

    // Expected words per queue as {last, data}
    logic [`QSYS_DATA_W:0] sb [NUM_Q][$];

    integer seed = 32'h4515_74ce;
    int     value_errors;
    int     other_errors;
    // Packets marked for admission in the cases file so far
    int     num_admit;
    // 0 all ready, 1 random per port, 2 blocked port held low
    int     ready_mode;
    bit     release_phase;
    bit     lo_seen_p2;

    queue_system queue_system_inst (
        .core_clk_ifc    (core_clk_ifc),
        .rst             (rst),
        .in_word         (in_word),
        .egr_buf_ready   (egr_buf_ready),
        .in_cnt_clear    (in_cnt_clear),
        .enq_cnt_clear   (enq_cnt_clear),
        .deq_cnt_clear   (deq_cnt_clear),
        .out_word        (out_word),
        .qsys_in_pkt_cnt (qsys_in_pkt_cnt),
        .enqueue_pkt_cnt (enqueue_pkt_cnt),
        .dequeue_pkt_cnt (dequeue_pkt_cnt)
    );

    initial begin
        core_clk_ifc = 1'b0;
        forever #20 core_clk_ifc = ~core_clk_ifc;
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        value_errors++;
        $display("Fail %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
    endtask

    // Next falling edge with the input idle and the ready pattern applied
    task automatic next_cycle();
        integer rnd;
        @(negedge core_clk_ifc);
        in_word = '0;
        rnd     = $random(seed);
        case (ready_mode)
            1: egr_buf_ready = rnd[`QSYS_NUM_EGR_PORTS-1:0];
            2: begin
                egr_buf_ready               = '1;
                egr_buf_ready[BLOCKED_PORT] = 1'b0;
            end
            default: egr_buf_ready = '1;
        endcase
    endtask

    function automatic int pending_words();
        int total;
        total = 0;
        for (int q = 0; q < NUM_Q; q++) begin
            total += sb[q].size();
        end
        return total;
    endfunction

    task automatic wait_for_drain();
        int cycles;
        cycles = 0;
        while (pending_words() != 0 && cycles < WAIT_LIMIT) begin
            next_cycle();
            cycles++;
        end
        if (pending_words() != 0) begin
            other_errors++;
            $display("Timed out after %0d cycles with %0d expected words not yet output",
                     cycles, pending_words());
        end
    endtask

    // One packet, following the previous one with no gap
    task automatic send_packet(input qsys_pkg::pkt_meta_t meta, input bit admit);
        int                      nwords;
        int                      qidx;
        logic [`QSYS_DATA_W-1:0] payload;
        nwords = (int'(meta.byte_length) + 3) / 4;
        qidx   = int'(meta.egress_port) * 2 + int'(meta.prio);
        for (int w = 0; w < nwords; w++) begin
            next_cycle();
            payload       = $random(seed);
            in_word.valid = 1'b1;
            in_word.last  = (w == nwords - 1);
            in_word.data  = payload;
            if (w == 0) begin
                // Admit decision of the previous packet is counted by now
                if (enqueue_pkt_cnt != 32'(num_admit)) begin
                    report_mismatch("enqueue_pkt_cnt", enqueue_pkt_cnt, 32'(num_admit));
                end
                in_word.meta = meta;
                if (admit) begin
                    num_admit++;
                end
            end
            if (admit) begin
                sb[qidx].push_back({in_word.last, payload});
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Output monitor

    always @(posedge core_clk_ifc) begin : output_monitor
        int                    q;
        logic [`QSYS_DATA_W:0] expected;
        if (!rst && out_word.valid) begin
            q = int'(out_word.egress_port) * 2 + int'(out_word.prio);
            if (!egr_buf_ready[out_word.egress_port]) begin
                other_errors++;
                $display("Output word on port %0d while its ready was low at %0t",
                         out_word.egress_port, $time);
            end
            if (release_phase && int'(out_word.egress_port) == BLOCKED_PORT) begin
                if (!out_word.prio) begin
                    lo_seen_p2 = 1'b1;
                end else if (lo_seen_p2) begin
                    other_errors++;
                    $display("High-priority word on port 2 after a low-priority one at %0t",
                             $time);
                end
            end
            if (sb[q].size() == 0) begin
                other_errors++;
                $display("Unexpected output word on port %0d prio %0d at %0t",
                         out_word.egress_port, out_word.prio, $time);
            end else begin
                expected = sb[q].pop_front();
                if (out_word.data != expected[`QSYS_DATA_W-1:0]) begin
                    report_mismatch("out_word.data", out_word.data,
                                    expected[`QSYS_DATA_W-1:0]);
                end
                if (out_word.last != expected[`QSYS_DATA_W]) begin
                    report_mismatch("out_word.last", 32'(out_word.last),
                                    32'(expected[`QSYS_DATA_W]));
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        integer              fd;
        integer              code;
        int                  ing;
        int                  egr;
        int                  prio;
        int                  blen;
        int                  admit;
        int                  phase;
        int                  num_lines;
        int                  cur_phase;
        bit                  done;
        qsys_pkg::pkt_meta_t meta;

        in_word       = '0;
        egr_buf_ready = '1;
        in_cnt_clear  = 1'b0;
        enq_cnt_clear = 1'b0;
        deq_cnt_clear = 1'b0;
        rst           = 1'b1;
        value_errors  = 0;
        other_errors  = 0;
        ready_mode    = 0;
        release_phase = 1'b0;
        lo_seen_p2    = 1'b0;
        num_lines     = 0;
        num_admit     = 0;
        cur_phase     = 0;
        done          = 1'b0;

        repeat (3) @(posedge core_clk_ifc);
        next_cycle();
        rst = 1'b0;

        fd = $fopen("test/queue_system_cases.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("Could not open the cases file");
        end else begin
            while (!done) begin
                code = $fscanf(fd, "%d %d %d %d %d %d\n", ing, egr, prio, blen, admit, phase);
                if (code != 6) begin
                    done = 1'b1;
                end else begin
                    // New phase starts from empty queues
                    if (phase != cur_phase) begin
                        wait_for_drain();
                        cur_phase  = phase;
                        ready_mode = phase;
                    end
                    meta.ingress_port = ing[`QSYS_ING_W-1:0];
                    meta.egress_port  = egr[`QSYS_PORT_W-1:0];
                    meta.prio         = prio[0];
                    meta.byte_length  = blen[`QSYS_BLEN_W-1:0];
                    send_packet(meta, admit != 0);
                    num_lines++;
                end
            end
            $fclose(fd);
        end
        if (num_lines == 0) begin
            other_errors++;
            $display("No packets were read from the cases file");
        end

        // Final write lands, then its packet count rises
        next_cycle();
        next_cycle();
        lo_seen_p2    = 1'b0;
        release_phase = 1'b1;
        ready_mode    = 0;
        wait_for_drain();
        release_phase = 1'b0;
        next_cycle();

        if (qsys_in_pkt_cnt != 32'(num_lines)) begin
            report_mismatch("qsys_in_pkt_cnt", qsys_in_pkt_cnt, 32'(num_lines));
        end
        if (enqueue_pkt_cnt != 32'(num_admit)) begin
            report_mismatch("enqueue_pkt_cnt", enqueue_pkt_cnt, 32'(num_admit));
        end
        if (dequeue_pkt_cnt != 32'(num_admit)) begin
            report_mismatch("dequeue_pkt_cnt", dequeue_pkt_cnt, 32'(num_admit));
        end

        // Clear strobes one at a time
        in_cnt_clear = 1'b1;
        next_cycle();
        in_cnt_clear  = 1'b0;
        enq_cnt_clear = 1'b1;
        if (qsys_in_pkt_cnt != '0) begin
            report_mismatch("qsys_in_pkt_cnt", qsys_in_pkt_cnt, 32'h0);
        end
        if (enqueue_pkt_cnt != 32'(num_admit)) begin
            report_mismatch("enqueue_pkt_cnt", enqueue_pkt_cnt, 32'(num_admit));
        end
        next_cycle();
        enq_cnt_clear = 1'b0;
        deq_cnt_clear = 1'b1;
        if (enqueue_pkt_cnt != '0) begin
            report_mismatch("enqueue_pkt_cnt", enqueue_pkt_cnt, 32'h0);
        end
        next_cycle();
        deq_cnt_clear = 1'b0;
        if (dequeue_pkt_cnt != '0) begin
            report_mismatch("dequeue_pkt_cnt", dequeue_pkt_cnt, 32'h0);
        end

        $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+hw
hw/qsys_pkg.sv
hw/packet_classifier.sv
hw/queue_memory.sv
hw/egress_scheduler.sv
hw/queue_system.sv
test/queue_system_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps
TOP       = queue_system_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Done: no errors

.PHONY: sim clean

# The run passes only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- test/queue_system_cases.txt
0 0 0 12 1 0
1 0 1 64 1 0
2 1 0 1 1 0
3 1 1 33 1 0
0 2 0 20 1 0
1 2 1 7 1 0
2 3 0 48 1 0
3 3 1 5 1 0
0 3 1 64 1 1
1 1 0 16 1 1
2 0 1 44 1 1
3 2 0 9 1 1
0 2 0 64 1 2
1 2 1 40 1 2
2 2 0 60 1 2
3 2 0 8 0 2
0 2 0 4 1 2
1 2 1 64 1 2
2 2 1 28 0 2
